/* filelist.f */
+incdir+include
source/align_data_pkg.sv
source/align_ctrl_pkg.sv
source/trans_desc_reg.sv
source/align_buffer.sv
source/align_ctrl_fsm.sv
source/trans_aligner_top.sv
tests/tb_trans_aligner.sv

/* source/align_buffer.sv */
`timescale 1ns/1ns

/*
 * Alignment buffer
 * Sixteen bytes in two beat-wide halves; push beats land in alternate
 * halves and a rotating crossbar reads a realigned beat across them
 */
module align_buffer
(
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  align_data_pkg::beat_data_t push_dat_i,
   input  logic                       push_we_i,
   input  logic                       push_half_i,
   input  logic                       pop_half_i,
   input  align_data_pkg::buf_idx_t   shift_i,
   output align_data_pkg::beat_data_t pop_dat_o
);

   logic [align_data_pkg::BUF_BYTES-1:0][align_data_pkg::BYTE_W-1:0] buf_q;

   // ******************************
   // Write steering
   // ******************************

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         buf_q <= '0;
      end
      else if (push_we_i)
      begin
         for (int j = 0; j < align_data_pkg::NUM_LANES; j++)
         begin
            buf_q[{push_half_i, align_data_pkg::lane_idx_t'(j)}] <=
               push_dat_i[j*align_data_pkg::BYTE_W +: align_data_pkg::BYTE_W];
         end
      end
   end

   // ******************************
   // Rotating read crossbar
   // ******************************

   // Lane j reads byte (8*half + j + shift) mod 16, which
   // wraps into the other half when the pop beat straddles two push beats
   for (genvar j = 0; j < align_data_pkg::NUM_LANES; j++)
   begin : g_rd_lane
      align_data_pkg::buf_idx_t rd_idx;

      assign rd_idx = {pop_half_i, align_data_pkg::lane_idx_t'(j)} + shift_i;

      assign pop_dat_o[j*align_data_pkg::BYTE_W +: align_data_pkg::BYTE_W] = buf_q[rd_idx];
   end

endmodule

/* source/align_ctrl_fsm.sv */
`timescale 1ns/1ns

/*
 * Transaction control
 * Two-state FSM with push and pop beat counters; the data grants follow
 * from which push beats each pop beat needs in the two-half buffer
 */
module align_ctrl_fsm
(
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  logic                       trans_req_i,
   input  logic                       data_push_req_i,
   input  logic                       data_pop_req_i,
   input  align_ctrl_pkg::desc_info_t  desc_info_i,
   output logic                       trans_gnt_o,
   output logic                       load_o,
   output logic                       data_push_gnt_o,
   output logic                       data_pop_gnt_o,
   output align_data_pkg::byte_strb_t data_pop_strb_o,
   output logic                       push_we_o,
   output logic                       push_half_o,
   output logic                       pop_half_o
);

   align_ctrl_pkg::ctrl_state_t state_q;
   align_ctrl_pkg::ctrl_state_t state_d;

   // Pushes done (m) and pops done (k)
   align_ctrl_pkg::beat_cnt_t push_cnt_q;
   align_ctrl_pkg::beat_cnt_t pop_cnt_q;

   // Lowest and highest push beat that pop beat k reads
   align_ctrl_pkg::beat_cnt_t low_beat;
   align_ctrl_pkg::beat_cnt_t need_raw;
   align_ctrl_pkg::beat_cnt_t need_beat;

   logic push_half_q;
   logic pop_half_q;
   logic busy;
   logic push_ahead;
   logic push_xfer;
   logic pop_xfer;
   logic last_pop;

   assign busy        = (state_q == align_ctrl_pkg::CTRL_BUSY);
   assign trans_gnt_o = (state_q == align_ctrl_pkg::CTRL_IDLE);
   assign load_o      = trans_req_i & trans_gnt_o;

   // ******************************
   // Beat window of pop k
   // ******************************

   // Push lane above pop lane: pop beat k also reaches into push beat k+1
   assign push_ahead = !desc_info_i.pop_greater && (desc_info_i.shift != '0);

   // Pop lane above push lane: pop beat k starts in push beat k-1
   assign low_beat = (desc_info_i.pop_greater && pop_cnt_q != '0) ? pop_cnt_q - 1'b1
                                                                 : pop_cnt_q;

   assign need_raw  = pop_cnt_q + align_ctrl_pkg::beat_cnt_t'(push_ahead);
   assign need_beat = (need_raw < desc_info_i.push_beats) ? need_raw
                                                           : desc_info_i.push_beats - 1'b1;

   // ******************************
   // Grants and strobe
   // ******************************

   // A push may only overwrite the half holding beat m-2, so stay within low+1
   assign data_push_gnt_o = busy && (push_cnt_q < desc_info_i.push_beats)
                                 && (push_cnt_q <= low_beat + 1'b1);
   assign data_pop_gnt_o  = busy && (pop_cnt_q < desc_info_i.pop_beats)
                                 && (push_cnt_q > need_beat);

   assign push_xfer = data_push_req_i & data_push_gnt_o;
   assign pop_xfer  = data_pop_req_i & data_pop_gnt_o;
   assign last_pop  = (pop_cnt_q == desc_info_i.pop_beats - 1'b1);

   always_comb
   begin
      data_pop_strb_o = '1;
      if (pop_cnt_q == '0)
         data_pop_strb_o = data_pop_strb_o & desc_info_i.first_strb;
      if (last_pop)
         data_pop_strb_o = data_pop_strb_o & desc_info_i.last_strb;
      if (!busy)
         data_pop_strb_o = '0;
   end

   assign push_we_o   = push_xfer;
   assign push_half_o = push_half_q;
   assign pop_half_o  = pop_half_q;

   // ******************************
   // State and counters
   // ******************************

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         align_ctrl_pkg::CTRL_IDLE:
         begin
            if (trans_req_i)
               state_d = align_ctrl_pkg::CTRL_BUSY;
         end
         align_ctrl_pkg::CTRL_BUSY:
         begin
            if (pop_xfer && last_pop)
               state_d = align_ctrl_pkg::CTRL_IDLE;
         end
         default:
            state_d = align_ctrl_pkg::CTRL_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q     <= align_ctrl_pkg::CTRL_IDLE;
         push_cnt_q  <= '0;
         pop_cnt_q   <= '0;
         push_half_q <= 1'b0;
         pop_half_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (load_o)
         begin
            push_cnt_q  <= '0;
            pop_cnt_q   <= '0;
            push_half_q <= 1'b0;
            pop_half_q  <= 1'b0;
         end
         else
         begin
            if (push_xfer)
            begin
               push_cnt_q  <= push_cnt_q + 1'b1;
               push_half_q <= ~push_half_q;
            end
            if (pop_xfer)
            begin
               pop_cnt_q  <= pop_cnt_q + 1'b1;
               pop_half_q <= ~pop_half_q;
            end
         end
      end
   end

endmodule

/* source/align_ctrl_pkg.sv */
/*
 * Control definitions for the byte-lane realigner
 * Transfer descriptor, derived transfer values and FSM states
 */
package align_ctrl_pkg;

   // ******************************
   // Descriptor
   // ******************************

   // Length field holds the byte count minus one
   localparam int LEN_W = 15;

   typedef logic [LEN_W-1:0] trans_len_t;

   // Up to 2^LEN_W bytes plus a lane offset, in 8-byte beats
   typedef logic [LEN_W-3:0] beat_cnt_t;

   typedef struct packed {
      align_data_pkg::lane_idx_t pop_addr;
      align_data_pkg::lane_idx_t push_addr;
      trans_len_t                len;
   } trans_desc_t;

   // ******************************
   // Derived values
   // ******************************

   typedef struct packed {
      beat_cnt_t                  push_beats;
      beat_cnt_t                  pop_beats;
      // Push lane minus pop lane, mod 16
      align_data_pkg::buf_idx_t   shift;
      logic                       pop_greater;
      align_data_pkg::byte_strb_t first_strb;
      align_data_pkg::byte_strb_t last_strb;
   } desc_info_t;

   // Transaction FSM
   typedef enum logic {
      CTRL_IDLE,
      CTRL_BUSY
   } ctrl_state_t;

endpackage

/* source/align_data_pkg.sv */
/*
 * Data path definitions for the byte-lane realigner
 * Beat and buffer geometry, lane strobes and lane indices
 */
package align_data_pkg;

   // ******************************
   // Geometry
   // ******************************

   // Byte lanes in one beat
   localparam int NUM_LANES = 8;
   localparam int BYTE_W    = 8;
   // Two beat-wide halves in the alignment buffer
   localparam int BUF_BYTES = 2 * NUM_LANES;

   // ******************************
   // Types
   // ******************************

   typedef logic [NUM_LANES*BYTE_W-1:0] beat_data_t;
   typedef logic [NUM_LANES-1:0]        byte_strb_t;

   // Byte position inside one beat
   typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

   // Byte position inside the whole buffer
   typedef logic [$clog2(BUF_BYTES)-1:0] buf_idx_t;

endpackage

/* source/trans_aligner_top.sv */
`timescale 1ns/1ns

/*
 * Byte-lane realigner for the DMA data path
 * Moves len+1 bytes from push lane push_addr to pop lane pop_addr
 */
module trans_aligner_top
(
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        trans_req_i,
   input  align_ctrl_pkg::trans_desc_t trans_desc_i,
   output logic                        trans_gnt_o,
   input  align_data_pkg::beat_data_t  data_push_dat_i,
   input  logic                        data_push_req_i,
   output logic                        data_push_gnt_o,
   output align_data_pkg::beat_data_t  data_pop_dat_o,
   output align_data_pkg::byte_strb_t  data_pop_strb_o,
   input  logic                        data_pop_req_i,
   output logic                        data_pop_gnt_o
);

   align_ctrl_pkg::desc_info_t desc_info;

   logic load;
   logic push_we;
   logic push_half;
   logic pop_half;

   trans_desc_reg i_desc_reg (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .trans_desc_i (trans_desc_i),
      .load_i       (load),
      .desc_info_o  (desc_info)
   );

   align_ctrl_fsm i_ctrl_fsm (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .trans_req_i     (trans_req_i),
      .data_push_req_i (data_push_req_i),
      .data_pop_req_i  (data_pop_req_i),
      .desc_info_i     (desc_info),
      .trans_gnt_o     (trans_gnt_o),
      .load_o          (load),
      .data_push_gnt_o (data_push_gnt_o),
      .data_pop_gnt_o  (data_pop_gnt_o),
      .data_pop_strb_o (data_pop_strb_o),
      .push_we_o       (push_we),
      .push_half_o     (push_half),
      .pop_half_o      (pop_half)
   );

   align_buffer i_buffer (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .push_dat_i  (data_push_dat_i),
      .push_we_i   (push_we),
      .push_half_i (push_half),
      .pop_half_i  (pop_half),
      .shift_i     (desc_info.shift),
      .pop_dat_o   (data_pop_dat_o)
   );

endmodule

/* source/trans_desc_reg.sv */
`timescale 1ns/1ns

/*
 * Descriptor register
 * Holds the accepted transfer descriptor and derives the beat counts,
 * the buffer lane shift and the first and last pop strobes from it
 */
module trans_desc_reg
(
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  align_ctrl_pkg::trans_desc_t trans_desc_i,
   input  logic                       load_i,
   output align_ctrl_pkg::desc_info_t  desc_info_o
);

   align_ctrl_pkg::trans_desc_t desc_q;

   // Lane position of the last byte, counted from lane 0 of beat 0
   logic [align_ctrl_pkg::LEN_W:0] push_end;
   logic [align_ctrl_pkg::LEN_W:0] pop_end;

   align_data_pkg::lane_idx_t last_lane;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         desc_q <= '0;
      else if (load_i)
         desc_q <= trans_desc_i;
   end

   assign push_end  = (align_ctrl_pkg::LEN_W + 1)'(desc_q.push_addr) + desc_q.len;
   assign pop_end   = (align_ctrl_pkg::LEN_W + 1)'(desc_q.pop_addr) + desc_q.len;
   assign last_lane = pop_end[2:0];

   always_comb
   begin
      // ceil((addr + len + 1) / 8) == floor((addr + len) / 8) + 1
      desc_info_o.push_beats = push_end[align_ctrl_pkg::LEN_W:3] + 1'b1;
      desc_info_o.pop_beats  = pop_end[align_ctrl_pkg::LEN_W:3] + 1'b1;

      desc_info_o.shift = align_data_pkg::buf_idx_t'(desc_q.push_addr)
                        - align_data_pkg::buf_idx_t'(desc_q.pop_addr);

      desc_info_o.pop_greater = (desc_q.pop_addr > desc_q.push_addr);

      // Edge strobes, the FSM combines them for a single-beat pop
      desc_info_o.first_strb = align_data_pkg::byte_strb_t'('1) << desc_q.pop_addr;
      desc_info_o.last_strb  = align_data_pkg::byte_strb_t'('1) >> (3'd7 - last_lane);
   end

endmodule

/* include/align_model.svh */
`ifndef ALIGN_MODEL_SVH
`define ALIGN_MODEL_SVH

/*
 * Reference model of the byte-lane realigner
 * Expected beat counts, pop strobes, push window and byte stream
 */

// Beats spanned by len+1 bytes starting at lane addr
task automatic model_beats(input int unsigned addr, input int unsigned len, output int beats);
   beats = (addr + len) / 8 + 1;
endtask

// Strobe of pop beat k out of pop_beats
task automatic model_pop_strb(input int unsigned pop_addr, input int unsigned len,
                              input int k, input int pop_beats, output logic [7:0] strb);
   strb = 8'hff;
   if (k == 0)
      strb = strb & (8'hff << pop_addr);
   if (k == pop_beats - 1)
      strb = strb & (8'hff >> (7 - ((pop_addr + len) % 8)));
endtask

// Lowest push beat that pop beat k reads
task automatic model_low(input int unsigned push_addr, input int unsigned pop_addr,
                         input int k, output int low);
   int pos;
   pos = 8 * k + int'(push_addr) - int'(pop_addr);
   low = (pos < 0) ? 0 : pos / 8;
endtask

// Source bytes from lane push_addr of the first push beat onward
task automatic model_expected_bytes(input logic [63:0] push_beats[$],
                                    input int unsigned push_addr,
                                    input int unsigned len,
                                    output logic [7:0] exp_bytes[$]);
   int unsigned pos;
   exp_bytes = {};
   for (int unsigned b = 0; b <= len; b++)
   begin
      pos = push_addr + b;
      exp_bytes.push_back(push_beats[pos / 8][8 * (pos % 8) +: 8]);
   end
endtask

`endif

/* tests/tb_trans_aligner.sv */
`timescale 1ns/1ns

/*
 * Testbench for the byte-lane realigner
 * Random descriptors, random source bytes and random stalls on both
 * data ports, checked against the reference model
 */
module tb_trans_aligner;

   `include "align_model.svh"

   localparam int NUM_TRANS = 200;
   localparam int TIMEOUT   = 2000;

   logic                        clk_i;
   logic                        rst_ni;
   logic                        trans_req_i;
   align_ctrl_pkg::trans_desc_t trans_desc_i;
   logic                        trans_gnt_o;
   align_data_pkg::beat_data_t  data_push_dat_i;
   logic                        data_push_req_i;
   logic                        data_push_gnt_o;
   align_data_pkg::beat_data_t  data_pop_dat_o;
   align_data_pkg::byte_strb_t  data_pop_strb_o;
   logic                        data_pop_req_i;
   logic                        data_pop_gnt_o;

   trans_aligner_top uut (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .trans_req_i     (trans_req_i),
      .trans_desc_i    (trans_desc_i),
      .trans_gnt_o     (trans_gnt_o),
      .data_push_dat_i (data_push_dat_i),
      .data_push_req_i (data_push_req_i),
      .data_push_gnt_o (data_push_gnt_o),
      .data_pop_dat_o  (data_pop_dat_o),
      .data_pop_strb_o (data_pop_strb_o),
      .data_pop_req_i  (data_pop_req_i),
      .data_pop_gnt_o  (data_pop_gnt_o)
   );

   always #5 clk_i = ~clk_i;

   // ******************************
   // Error reporting
   // ******************************

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
      $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, got);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
      $display("test failed");
      $fatal(1);
   endtask

   // ******************************
   // One transaction
   // ******************************

   task automatic run_transaction();
      int          len;
      int          push_addr;
      int          pop_addr;
      int          push_beats;
      int          pop_beats;
      int          m;
      int          k;
      int          low;
      int          need;
      int          cycles;
      int          stall_left;
      logic [63:0] src[$];
      logic [7:0]  exp_bytes[$];
      logic [7:0]  got_bytes[$];
      logic [7:0]  exp_strb;
      logic        exp_gnt;
      logic        push_req;
      logic        pop_req;

      len       = $urandom_range(63, 0);
      push_addr = $urandom_range(7, 0);
      pop_addr  = $urandom_range(7, 0);
      model_beats(push_addr, len, push_beats);
      model_beats(pop_addr, len, pop_beats);
      src = {};
      for (int b = 0; b < push_beats; b++)
         src.push_back({$urandom, $urandom});
      model_expected_bytes(src, push_addr, len, exp_bytes);
      got_bytes = {};

      // Descriptor is only taken in idle
      cycles = 0;
      while (!trans_gnt_o)
      begin
         @(negedge clk_i);
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("trans_gnt_o to return high");
      end
      trans_req_i            = 1'b1;
      trans_desc_i.len       = align_ctrl_pkg::trans_len_t'(len);
      trans_desc_i.push_addr = align_data_pkg::lane_idx_t'(push_addr);
      trans_desc_i.pop_addr  = align_data_pkg::lane_idx_t'(pop_addr);
      @(negedge clk_i);
      trans_req_i = 1'b0;

      m          = 0;
      k          = 0;
      cycles     = 0;
      stall_left = 0;
      while (k < pop_beats)
      begin
         // Grants follow the push window of pop beat k
         model_low(push_addr, pop_addr, k, low);
         need = (8 * k + 7 + push_addr - pop_addr) / 8;
         if (need > push_beats - 1)
            need = push_beats - 1;
         assert (trans_gnt_o == 1'b0)
            else report_mismatch("trans_gnt_o", 1'b0, trans_gnt_o);
         exp_gnt = (m < push_beats) && (m <= low + 1);
         assert (data_push_gnt_o == exp_gnt)
            else report_mismatch("data_push_gnt_o", exp_gnt, data_push_gnt_o);
         exp_gnt = (k < pop_beats) && (m > need);
         assert (data_pop_gnt_o == exp_gnt)
            else report_mismatch("data_pop_gnt_o", exp_gnt, data_pop_gnt_o);

         // Sink goes quiet now and then for a long stretch
         push_req = ($urandom_range(99, 0) >= 30);
         if (stall_left > 0)
         begin
            pop_req = 1'b0;
            stall_left--;
         end
         else if ($urandom_range(99, 0) < 3)
         begin
            pop_req    = 1'b0;
            stall_left = $urandom_range(30, 8);
         end
         else
            pop_req = ($urandom_range(99, 0) >= 30);

         data_push_req_i = push_req;
         data_pop_req_i  = pop_req;
         data_push_dat_i = (m < push_beats) ? src[m] : {$urandom, $urandom};
         if (push_req && data_push_gnt_o)
            m++;
         if (pop_req && data_pop_gnt_o)
         begin
            model_pop_strb(pop_addr, len, k, pop_beats, exp_strb);
            assert (data_pop_strb_o == exp_strb)
               else report_mismatch("data_pop_strb_o", exp_strb, data_pop_strb_o);
            for (int j = 0; j < 8; j++)
            begin
               if (data_pop_strb_o[j])
                  got_bytes.push_back(data_pop_dat_o[8*j +: 8]);
            end
            k++;
         end
         @(negedge clk_i);
         cycles++;
         if (cycles > TIMEOUT)
            report_timeout("the last pop transfer");
      end
      data_push_req_i = 1'b0;
      data_pop_req_i  = 1'b0;

      // Transaction is over, compare counts and the byte stream
      assert (trans_gnt_o == 1'b1)
         else report_mismatch("trans_gnt_o", 1'b1, trans_gnt_o);
      assert (m == push_beats)
         else report_mismatch("push transfer count", push_beats, m);
      assert (got_bytes.size() == len + 1)
         else report_mismatch("popped byte count", len + 1, got_bytes.size());
      for (int i = 0; i <= len; i++)
      begin
         assert (got_bytes[i] == exp_bytes[i])
            else report_mismatch("data_pop_dat_o byte", exp_bytes[i], got_bytes[i]);
      end
   endtask

   // ******************************
   // Main sequence
   // ******************************

   initial
   begin
      void'($urandom(19));
      clk_i           = 1'b0;
      rst_ni          = 1'b0;
      trans_req_i     = 1'b0;
      trans_desc_i    = '0;
      data_push_dat_i = '0;
      data_push_req_i = 1'b0;
      data_pop_req_i  = 1'b0;

      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;

      // Idle after reset
      assert (trans_gnt_o == 1'b1)
         else report_mismatch("trans_gnt_o", 1'b1, trans_gnt_o);
      assert (data_push_gnt_o == 1'b0)
         else report_mismatch("data_push_gnt_o", 1'b0, data_push_gnt_o);
      assert (data_pop_gnt_o == 1'b0)
         else report_mismatch("data_pop_gnt_o", 1'b0, data_pop_gnt_o);

      for (int t = 0; t < NUM_TRANS; t++)
         run_transaction();

      $display("test passed");
      $finish;
   end

endmodule
